// ==== Bender.yml ====
package:
  name: sampler

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/bus_pkg.sv
      - hdl/sample_pkg.sv
      - hdl/probe_bank.sv
      - hdl/sample_fifo.sv
      - hdl/sample_collector.sv
      - hdl/sampler_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_sampler_top.sv

// ==== hdl/bus_pkg.sv ====
// command bus encodings shared by the collector, the probe bank and the testbench
`default_nettype none

package bus_pkg;

  // addr[7:0] offsets within a page
  typedef enum logic [7:0] {
    ADDR_PROBE_DATA    = 8'd0,  // probe page, measured value register
    ADDR_NEW_UNIT      = 8'd4,  // collector page, append a unit position
    ADDR_LOCAL_COMMAND = 8'd5   // collector page, command register
  } reg_offset_e;

  // values written to ADDR_LOCAL_COMMAND
  // the full 32-bit data word is latched, unknown codes are discarded in idle
  typedef enum logic [31:0] {
    CMD_NONE           = 32'd0,
    CMD_START_SAMPLING = 32'd1,
    CMD_STOP_SAMPLING  = 32'd2,
    CMD_RESET          = 32'd5  // stop and forget all registered units
  } cmd_e;

endpackage

`default_nettype wire

// ==== hdl/probe_bank.sv ====
// bank of bus-writable probe registers, presents the selected probe as sample_data on request
`timescale 1ns/100ps
`default_nettype none

`include "collector_defs.svh"

module probe_bank (
  input  wire         clk,
  input  wire         rst,
  input  wire  [15:0] addr,
  input  wire  [31:0] cmd_data_in,
  input  wire         cs,
  input  wire         wr,
  input  wire  [7:0]  channel_select,  // bus position from the collector
  input  wire         output_sample,
  output logic [31:0] sample_data
);

  logic [`SAMPLE_BITS-1:0] probe_val [`NUM_UNITS];  // measured values
  logic                    probe_wr;
  logic [`SLOT_BITS-1:0]   wr_idx;
  logic [`SLOT_BITS-1:0]   rd_idx;
  logic                    rd_known;

  // probe pages are bus positions 0..NUM_UNITS-1
  assign probe_wr = cs && wr && (addr[15:8] < `NUM_UNITS)
                    && (addr[7:0] == bus_pkg::ADDR_PROBE_DATA);
  assign wr_idx   = addr[8 +: `SLOT_BITS];
  assign rd_idx   = channel_select[`SLOT_BITS-1:0];
  assign rd_known = channel_select < `NUM_UNITS;  // NO_UNIT and 8+ fall out here

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_UNITS; i++) begin
        probe_val[i] <= '0;
      end
      sample_data <= '0;
    end else begin
      if (probe_wr) begin
        probe_val[wr_idx] <= cmd_data_in[`SAMPLE_BITS-1:0];  // upper data bits ignored
      end
      // one cycle from output_sample to sample_data
      if (output_sample) begin
        if (rd_known) begin
          sample_data <= {{(32-`SAMPLE_BITS){1'b0}}, probe_val[rd_idx]};
        end else begin
          sample_data <= '0;  // unknown position reads 0
        end
      end
    end
  end

  // the collector keeps only SAMPLE_BITS, anything above would be silently lost
  a_sample_width: assert property (@(posedge clk) disable iff (rst)
    sample_data[31:`SAMPLE_BITS] == '0)
    else $error("probe_bank: sample_data has bits above SAMPLE_BITS set");

endmodule

`default_nettype wire

// ==== hdl/sample_collector.sv ====
// sample collector: bus command decode, unit list, round-robin scan and change-only FIFO feed
`timescale 1ns/100ps
`default_nettype none

`include "collector_defs.svh"

module sample_collector (
  input  wire         clk,
  input  wire         rst,
  input  wire  [15:0] addr,
  input  wire  [31:0] cmd_data_in,
  input  wire         cs,
  input  wire         wr,
  input  wire  [31:0] sample_data,     // from the probe bank, one cycle behind output_sample
  output logic        output_sample,
  output logic [7:0]  channel_select,  // bus position of the current slot
  output logic [15:0] fifo_din,
  output logic        fifo_wr_en
);

  // bus decode
  logic page_wr;
  logic new_unit_wr;
  logic cmd_wr;

  // unit list and scan position
  logic [7:0]            channels [`NUM_UNITS];  // bus positions in registration order
  logic [`SLOT_BITS:0]   num_units;              // 0..NUM_UNITS
  logic [`SLOT_BITS-1:0] slot_idx;
  logic [`SLOT_BITS:0]   slot_next;              // slot_idx + 1 with carry
  bus_pkg::cmd_e         command;

  // change detection
  logic [`SAMPLE_BITS-1:0] last_value [`NUM_UNITS];  // last value pushed per slot
  logic [`SAMPLE_BITS-1:0] new_value;

  // FSM
  sample_pkg::scan_state_e  state;
  sample_pkg::scan_state_e  next_state;
  sample_pkg::sample_word_u word;
  logic                     inc_slot;
  logic                     res_cmd;    // command consumed
  logic                     res_units;  // forget all units

  assign page_wr     = cs && wr && (addr[15:8] == `COLLECTOR_POSITION);
  assign new_unit_wr = page_wr && (addr[7:0] == bus_pkg::ADDR_NEW_UNIT);
  assign cmd_wr      = page_wr && (addr[7:0] == bus_pkg::ADDR_LOCAL_COMMAND);

  assign slot_next      = {1'b0, slot_idx} + 1'b1;
  assign channel_select = channels[slot_idx];  // NO_UNIT when nothing registered
  assign new_value      = sample_data[`SAMPLE_BITS-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= sample_pkg::idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state    = state;
    output_sample = 1'b0;
    fifo_wr_en    = 1'b0;
    inc_slot      = 1'b0;
    res_cmd       = 1'b0;
    res_units     = 1'b0;
    case (state)
      sample_pkg::idle: begin
        if (command == bus_pkg::CMD_START_SAMPLING) begin
          res_cmd    = 1'b1;
          next_state = sample_pkg::fetch;
        end else if (command == bus_pkg::CMD_RESET) begin
          res_cmd   = 1'b1;
          res_units = 1'b1;
        end else if (command != bus_pkg::CMD_NONE) begin
          res_cmd = 1'b1;  // stop or unknown code while idle, nothing to do
        end
      end
      sample_pkg::fetch: begin
        output_sample = 1'b1;  // probe bank latches the selected value
        next_state    = sample_pkg::fetch_wait;
      end
      sample_pkg::fetch_wait: begin
        output_sample = 1'b1;  // second request, value on sample_data in store
        next_state    = sample_pkg::store;
      end
      sample_pkg::store: begin
        // push only on a change
        fifo_wr_en = last_value[slot_idx] != new_value;
        next_state = sample_pkg::increment;
      end
      sample_pkg::increment: begin
        inc_slot   = 1'b1;
        next_state = sample_pkg::fetch;
        if (command == bus_pkg::CMD_RESET) begin
          res_cmd    = 1'b1;
          res_units  = 1'b1;
          next_state = sample_pkg::idle;
        end else if (command == bus_pkg::CMD_STOP_SAMPLING) begin
          res_cmd    = 1'b1;
          next_state = sample_pkg::idle;
        end
      end
      default: next_state = sample_pkg::idle;
    endcase
  end

  // unit list, command register, last values
  always_ff @(posedge clk) begin
    if (rst || res_units) begin
      for (int i = 0; i < `NUM_UNITS; i++) begin
        channels[i]   <= `NO_UNIT;
        last_value[i] <= '0;  // matches what an unknown position reads
      end
      num_units <= '0;
      slot_idx  <= '0;
      command   <= bus_pkg::CMD_NONE;
    end else begin
      if (res_cmd) begin
        command <= bus_pkg::CMD_NONE;
      end else if (cmd_wr) begin
        command <= bus_pkg::cmd_e'(cmd_data_in);
      end
      if (new_unit_wr && (num_units < `NUM_UNITS)) begin
        channels[num_units[`SLOT_BITS-1:0]] <= cmd_data_in[7:0];
        num_units <= num_units + 1'b1;
      end
      if (fifo_wr_en) begin
        last_value[slot_idx] <= new_value;
      end
      // wrap at num_units, stays at 0 with an empty list
      if (inc_slot) begin
        if (slot_next >= num_units) begin
          slot_idx <= '0;
        end else begin
          slot_idx <= slot_next[`SLOT_BITS-1:0];
        end
      end
    end
  end

  // slot index on top, sample below
  always_comb begin
    word.f.slot  = slot_idx;
    word.f.value = new_value;
  end
  assign fifo_din = word.raw;

  a_state_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot(state))
    else $error("sample_collector: state %b not one-hot", state);

  // software must not register more units than the list holds
  a_unit_room: assert property (@(posedge clk) disable iff (rst)
    new_unit_wr |-> num_units < `NUM_UNITS)
    else $error("sample_collector: new unit with list full");

  // a push always follows a full fetch/fetch_wait sequence
  a_wr_in_store: assert property (@(posedge clk) disable iff (rst)
    fifo_wr_en |-> (state == sample_pkg::store) && ($past(state) == sample_pkg::fetch_wait))
    else $error("sample_collector: FIFO write outside store");

endmodule

`default_nettype wire

// ==== hdl/sample_fifo.sv ====
// synchronous sample FIFO with registered read data and occupancy flags, drops writes when full
`timescale 1ns/100ps
`default_nettype none

`include "collector_defs.svh"

module sample_fifo (
  input  wire                                       clk,
  input  wire                                       rst,
  input  wire  [$bits(sample_pkg::sample_word_u)-1:0] din,
  input  wire                                       wr_en,
  input  wire                                       rd_en,
  output logic [$bits(sample_pkg::sample_word_u)-1:0] dout,
  output logic                                      full,
  output logic                                      almost_full,
  output logic                                      empty,
  output logic                                      almost_empty
);

  localparam int PTR_BITS  = $clog2(`FIFO_DEPTH);
  localparam int WORD_BITS = $bits(sample_pkg::sample_word_u);

  logic [WORD_BITS-1:0] mem [`FIFO_DEPTH];
  logic [PTR_BITS-1:0]  wr_ptr;
  logic [PTR_BITS-1:0]  rd_ptr;
  logic [PTR_BITS:0]    count;  // 0..FIFO_DEPTH
  logic                 wr_ok;
  logic                 rd_ok;

  assign wr_ok = wr_en && !full;   // overflow dropped
  assign rd_ok = rd_en && !empty;  // underflow ignored

  // flags straight from the count
  assign full         = count == `FIFO_DEPTH;
  assign almost_full  = count >= `FIFO_ALMOST_FULL;
  assign empty        = count == '0;
  assign almost_empty = count < `FIFO_ALMOST_EMPTY;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, wraps by itself
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  // storage and read register
  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= din;
    end
    if (rd_ok) begin
      dout <= mem[rd_ptr];  // head word visible the cycle after rd_en
    end
  end

  // the collector has no back-pressure, so a full FIFO loses samples
  a_no_wr_full: assert property (@(posedge clk) disable iff (rst)
    !(wr_en && full))
    else $error("sample_fifo: write while full, sample dropped");

  a_count_range: assert property (@(posedge clk) disable iff (rst)
    count <= `FIFO_DEPTH)
    else $error("sample_fifo: count %0d above depth", count);

endmodule

`default_nettype wire

// ==== hdl/sample_pkg.sv ====
// sample path types: the FIFO word as raw bits or slot/value fields, and the scan FSM states
`default_nettype none

`include "collector_defs.svh"

package sample_pkg;

  // field view of a FIFO word, slot in the top bits
  typedef struct packed {
    logic [`SLOT_BITS-1:0]   slot;   // index into the unit list, not the bus position
    logic [`SAMPLE_BITS-1:0] value;  // low bits of the probe value
  } sample_fields_t;

  // raw view at the FIFO and the top output, field view in collector and testbench
  typedef union packed {
    logic [15:0]    raw;
    sample_fields_t f;
  } sample_word_u;

  // one-hot scan states
  typedef enum logic [4:0] {
    idle       = 5'b00001,
    store      = 5'b00010,  // compare and maybe push
    increment  = 5'b00100,  // next slot, stop/reset taken here
    fetch      = 5'b01000,  // request the probe value
    fetch_wait = 5'b10000   // probe bank registers the value
  } scan_state_e;

endpackage

`default_nettype wire

// ==== hdl/sampler_top.sv ====
// sampler subsystem top: collector, probe bank and sample FIFO on the shared command bus
`timescale 1ns/100ps
`default_nettype none

module sampler_top (
  input  wire         clk,
  input  wire         rst,
  input  wire  [15:0] addr,
  input  wire  [31:0] cmd_data_in,
  input  wire         cs,
  input  wire         wr,
  input  wire         sample_fifo_rd_en,
  output logic        output_sample,
  output logic [7:0]  channel_select,
  output logic [15:0] sample_data_out,
  output logic        sample_fifo_empty,
  output logic        sample_fifo_almost_empty,
  output logic        sample_fifo_full,
  output logic        sample_fifo_almost_full
);

  logic [31:0] sample_data;  // probe bank to collector
  logic [15:0] fifo_din;
  logic        fifo_wr_en;

  sample_collector u_collector (
    .clk            (clk),
    .rst            (rst),
    .addr           (addr),
    .cmd_data_in    (cmd_data_in),
    .cs             (cs),
    .wr             (wr),
    .sample_data    (sample_data),
    .output_sample  (output_sample),
    .channel_select (channel_select),
    .fifo_din       (fifo_din),
    .fifo_wr_en     (fifo_wr_en)
  );

  probe_bank u_probes (
    .clk            (clk),
    .rst            (rst),
    .addr           (addr),
    .cmd_data_in    (cmd_data_in),
    .cs             (cs),
    .wr             (wr),
    .channel_select (channel_select),
    .output_sample  (output_sample),
    .sample_data    (sample_data)
  );

  sample_fifo u_fifo (
    .clk          (clk),
    .rst          (rst),
    .din          (fifo_din),
    .wr_en        (fifo_wr_en),
    .rd_en        (sample_fifo_rd_en),  // driven from outside
    .dout         (sample_data_out),
    .full         (sample_fifo_full),
    .almost_full  (sample_fifo_almost_full),
    .empty        (sample_fifo_empty),
    .almost_empty (sample_fifo_almost_empty)
  );

endmodule

`default_nettype wire

// ==== include/collector_defs.svh ====
// sizes and bus constants of the sample collector, included by packages and RTL that need them
`ifndef COLLECTOR_DEFS_SVH
`define COLLECTOR_DEFS_SVH

// page of the collector on the command bus, compared against addr[15:8]
`define COLLECTOR_POSITION 8'd242

// unit list and probe bank size
`define NUM_UNITS 8
`define SLOT_BITS 3  // slot index field, ties NUM_UNITS to 8

// stored sample width, low bits of the probe value
`define SAMPLE_BITS 13

// sample FIFO geometry
`define FIFO_DEPTH 32
`define FIFO_ALMOST_FULL 28  // almost_full at or above this count
`define FIFO_ALMOST_EMPTY 2  // almost_empty below this count

// channel list marker for an unused entry
`define NO_UNIT 8'd255

`endif

// ==== sources.f ====
+incdir+include
hdl/bus_pkg.sv
hdl/sample_pkg.sv
hdl/probe_bank.sv
hdl/sample_fifo.sv
hdl/sample_collector.sv
hdl/sampler_top.sv
tb/tb_sampler_top.sv

// ==== tb/tb_sampler_top.sv ====
// testbench for sampler_top, drives the command bus, drains the FIFO and checks by assertions
`timescale 1ns/100ps
`default_nettype none

`include "collector_defs.svh"

module tb_sampler_top;

  localparam int TIMEOUT_CYCLES = 6 * 400;  // 6 tests, 400 cycles each

  logic        clk;
  logic        rst;
  logic [15:0] addr;
  logic [31:0] cmd_data_in;
  logic        cs;
  logic        wr;
  logic        sample_fifo_rd_en;
  logic        output_sample;
  logic [7:0]  channel_select;
  logic [15:0] sample_data_out;
  logic        sample_fifo_empty;
  logic        sample_fifo_almost_empty;
  logic        sample_fifo_full;
  logic        sample_fifo_almost_full;

  // reference model
  logic [7:0]              chan_list [`NUM_UNITS];  // positions in registration order
  int                      n_units;
  logic [`SAMPLE_BITS-1:0] probe_ref [`NUM_UNITS];
  logic [`SAMPLE_BITS-1:0] last_ref [`NUM_UNITS];   // last word value per slot
  logic [15:0]             exp_q [$];               // words the FIFO should hold, in order
  int                      exp_count;
  int                      model_ptr;               // slot the next fetch visits
  logic                    model_reset;
  logic                    os_prev;
  logic [7:0]              exp_chan;
  logic [3:0]              exp_flags;
  logic [3:0]              dut_flags;

  // check enables, raised for one cycle by the stimulus
  logic        chk_word;
  logic [15:0] exp_word;
  logic        flag_chk;
  logic        idle_chk;

  logic [15:0]             lfsr;
  logic [`SAMPLE_BITS-1:0] val_a;
  logic [`SAMPLE_BITS-1:0] val_b;
  int                      err_count;
  int                      errs_start;
  int                      pass_count;
  int                      fail_count;
  int                      cycle_count;

  sampler_top u_dut (
    .clk                      (clk),
    .rst                      (rst),
    .addr                     (addr),
    .cmd_data_in              (cmd_data_in),
    .cs                       (cs),
    .wr                       (wr),
    .sample_fifo_rd_en        (sample_fifo_rd_en),
    .output_sample            (output_sample),
    .channel_select           (channel_select),
    .sample_data_out          (sample_data_out),
    .sample_fifo_empty        (sample_fifo_empty),
    .sample_fifo_almost_empty (sample_fifo_almost_empty),
    .sample_fifo_full         (sample_fifo_full),
    .sample_fifo_almost_full  (sample_fifo_almost_full)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // flags in order full, almost_full, empty, almost_empty
  assign dut_flags = {sample_fifo_full, sample_fifo_almost_full,
                      sample_fifo_empty, sample_fifo_almost_empty};
  assign exp_flags = {exp_count == `FIFO_DEPTH, exp_count >= `FIFO_ALMOST_FULL,
                      exp_count == 0, exp_count < `FIFO_ALMOST_EMPTY};
  assign exp_chan  = (n_units == 0) ? `NO_UNIT : chan_list[model_ptr];

  // one slot visit per rising output_sample, wrap at the unit count
  always @(posedge clk) begin
    os_prev <= output_sample;
    if (model_reset) begin
      model_ptr <= 0;
    end else if (!rst && output_sample && !os_prev) begin
      model_ptr <= (model_ptr + 1 >= n_units) ? 0 : model_ptr + 1;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  a_word: assert property (@(posedge clk) disable iff (rst)
    chk_word |-> sample_data_out == exp_word)
    else begin
      err_count++;
      $display("** Error: sample_data_out = 0x%h, expected 0x%h",
               $sampled(sample_data_out), $sampled(exp_word));
    end

  a_flags: assert property (@(posedge clk) disable iff (rst)
    flag_chk |-> dut_flags == exp_flags)
    else begin
      err_count++;
      $display("** Error: full/almost_full/empty/almost_empty = 0x%h, expected 0x%h",
               $sampled(dut_flags), $sampled(exp_flags));
    end

  a_chan: assert property (@(posedge clk) disable iff (rst)
    $rose(output_sample) |-> channel_select == exp_chan)
    else begin
      err_count++;
      $display("** Error: channel_select = 0x%h, expected 0x%h",
               $sampled(channel_select), $sampled(exp_chan));
    end

  a_idle: assert property (@(posedge clk) disable iff (rst)
    idle_chk |-> !output_sample)
    else begin
      err_count++;
      $display("** Error: output_sample = 0x%h, expected 0x0", $sampled(output_sample));
    end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Galois form, x^16+x^14+x^13+x^11+1
  endfunction

  // nonzero value that differs from avoid, one LFSR step per bit
  task automatic random_value(input logic [`SAMPLE_BITS-1:0] avoid,
                              output logic [`SAMPLE_BITS-1:0] v);
    v = avoid;
    while (v == avoid || v == '0) begin
      for (int i = 0; i < `SAMPLE_BITS; i++) begin
        lfsr = lfsr_next(lfsr);
        v[i] = lfsr[0];
      end
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;  // inputs change 1 ns after the edge
  endtask

  task automatic bus_write(input logic [15:0] a, input logic [31:0] d);
    addr        = a;
    cmd_data_in = d;
    cs          = 1'b1;
    wr          = 1'b1;
    wait_cycles(1);
    cs = 1'b0;
    wr = 1'b0;
  endtask

  task automatic add_unit(input logic [7:0] pos);
    bus_write({`COLLECTOR_POSITION, bus_pkg::ADDR_NEW_UNIT}, {24'd0, pos});
    chan_list[n_units] = pos;
    n_units++;
  endtask

  task automatic send_cmd(input bus_pkg::cmd_e cmd);
    bus_write({`COLLECTOR_POSITION, bus_pkg::ADDR_LOCAL_COMMAND}, cmd);
  endtask

  task automatic set_probe(input logic [7:0] pos, input logic [`SAMPLE_BITS-1:0] v);
    bus_write({pos, bus_pkg::ADDR_PROBE_DATA}, {19'd0, v});
    probe_ref[pos[`SLOT_BITS-1:0]] = v;
  endtask

  // queue a word for every slot whose value moved away from the last one queued
  task automatic expect_changes();
    sample_pkg::sample_word_u w;
    logic [`SAMPLE_BITS-1:0]  v;
    for (int s = 0; s < n_units; s++) begin
      v = (chan_list[s] < `NUM_UNITS) ? probe_ref[chan_list[s][`SLOT_BITS-1:0]] : '0;
      if (v != last_ref[s]) begin
        w.f.slot    = s[`SLOT_BITS-1:0];
        w.f.value   = v;
        last_ref[s] = v;
        exp_q.push_back(w.raw);
      end
    end
  endtask

  task automatic check_flags();
    exp_count = exp_q.size();
    flag_chk  = 1'b1;
    wait_cycles(1);
    flag_chk  = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() > 0) begin
      sample_fifo_rd_en = 1'b1;
      exp_word          = exp_q.pop_front();
      wait_cycles(1);
      sample_fifo_rd_en = 1'b0;
      chk_word          = 1'b1;  // head word on dout now
      check_flags();             // count one lower after the read edge
      chk_word          = 1'b0;
    end
  endtask

  // fetch count taken from rising output_sample
  task automatic count_visits(input int n);
    logic prev;
    int   seen;
    prev = output_sample;
    seen = 0;
    while (seen < n) begin
      wait_cycles(1);
      if (output_sample && !prev) begin
        seen++;
      end
      prev = output_sample;
    end
  endtask

  task automatic wait_stopped();
    int lows;
    lows = 0;
    while (lows < 6) begin  // a running scan is never low more than 2 cycles
      wait_cycles(1);
      lows = output_sample ? 0 : lows + 1;
    end
  endtask

  task automatic report(input string name);
    if (err_count == errs_start) begin
      pass_count++;
      $display("%s: pass", name);
    end else begin
      fail_count++;
      $display("%s: fail, %0d errors", name, err_count - errs_start);
    end
    errs_start = err_count;
  endtask

  initial begin
    rst               = 1'b1;
    addr              = '0;
    cmd_data_in       = '0;
    cs                = 1'b0;
    wr                = 1'b0;
    sample_fifo_rd_en = 1'b0;
    chk_word          = 1'b0;
    exp_word          = '0;
    flag_chk          = 1'b0;
    idle_chk          = 1'b0;
    model_reset       = 1'b1;
    os_prev           = 1'b0;
    lfsr              = 16'd19;
    n_units           = 0;
    exp_count         = 0;
    err_count         = 0;
    errs_start        = 0;
    pass_count        = 0;
    fail_count        = 0;
    cycle_count       = 0;
    for (int i = 0; i < `NUM_UNITS; i++) begin
      chan_list[i] = `NO_UNIT;
      probe_ref[i] = '0;
      last_ref[i]  = '0;
    end
    wait_cycles(2);
    rst         = 1'b0;
    model_reset = 1'b0;

    // 1: state after reset
    check_flags();
    idle_chk = 1'b1;
    wait_cycles(20);
    idle_chk = 1'b0;
    report("1 reset state");

    // 2: first round stores every slot, then one changed probe adds one word
    add_unit(8'd3);
    add_unit(8'd0);
    add_unit(8'd6);
    random_value('0, val_a);
    set_probe(8'd3, val_a);
    random_value('0, val_a);
    set_probe(8'd0, val_a);
    random_value('0, val_a);
    set_probe(8'd6, val_a);
    expect_changes();
    send_cmd(bus_pkg::CMD_START_SAMPLING);
    count_visits(n_units + 1);  // all three stores done
    send_cmd(bus_pkg::CMD_STOP_SAMPLING);
    wait_stopped();
    check_flags();
    drain();
    send_cmd(bus_pkg::CMD_START_SAMPLING);
    random_value(probe_ref[0], val_a);
    set_probe(8'd0, val_a);     // slot 1, written mid-scan
    expect_changes();
    count_visits(2 * n_units + 1);
    send_cmd(bus_pkg::CMD_STOP_SAMPLING);
    wait_stopped();
    check_flags();
    drain();
    report("2 collection");

    // 3: nothing new, unknown position reads 0 like the cleared last value
    add_unit(8'd200);
    expect_changes();
    send_cmd(bus_pkg::CMD_START_SAMPLING);
    wait_cycles(40);
    send_cmd(bus_pkg::CMD_STOP_SAMPLING);
    wait_stopped();
    check_flags();
    report("3 change detection");

    // 4: three full rounds over four units, order checked by a_chan
    send_cmd(bus_pkg::CMD_START_SAMPLING);
    count_visits(3 * n_units);
    send_cmd(bus_pkg::CMD_STOP_SAMPLING);
    wait_stopped();
    check_flags();
    report("4 channel order");

    // 5: reset command mid-scan forgets the units
    send_cmd(bus_pkg::CMD_START_SAMPLING);
    count_visits(2);
    send_cmd(bus_pkg::CMD_RESET);
    wait_stopped();
    n_units     = 0;
    model_reset = 1'b1;
    for (int i = 0; i < `NUM_UNITS; i++) begin
      chan_list[i] = `NO_UNIT;
      last_ref[i]  = '0;
    end
    wait_cycles(1);
    model_reset = 1'b0;
    random_value(probe_ref[3], val_a);
    set_probe(8'd3, val_a);
    random_value(probe_ref[0], val_a);
    set_probe(8'd0, val_a);
    expect_changes();  // empty list, nothing queued
    send_cmd(bus_pkg::CMD_START_SAMPLING);
    count_visits(3);
    send_cmd(bus_pkg::CMD_STOP_SAMPLING);
    wait_stopped();
    check_flags();
    report("5 reset command");

    // 6: fill to full with alternating values on one unit, then drain
    add_unit(8'd1);
    random_value('0, val_a);
    random_value(val_a, val_b);
    send_cmd(bus_pkg::CMD_START_SAMPLING);
    for (int i = 0; i < `FIFO_DEPTH; i++) begin
      set_probe(8'd1, i[0] ? val_b : val_a);
      expect_changes();
      wait_cycles(8);  // two 4-cycle rounds, the change is stored once
      check_flags();
    end
    send_cmd(bus_pkg::CMD_STOP_SAMPLING);
    wait_stopped();
    check_flags();
    drain();
    report("6 flags");

    $display("summary: %0d passed, %0d failed, %0d errors", pass_count, fail_count, err_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
